/* Bender.yml */
package:
  name: microCore8

sources:
  - microCore8Pkg.sv
  - alu8.sv
  - busSequencer.sv
  - opDecoder.sv
  - dataPath.sv
  - microCore8.sv
  - target: test
    files:
      - microCore8_chk.sv
      - microCore8Tb.sv

/* alu8.sv */
`timescale 1ns/1ps

module alu8
  import microCore8Pkg::*;
(
  input  aluOp_t aluOp,
  input  data_t  accOut,
  input  data_t  operand,
  input  data_t  flagsIn,
  output data_t  aluResult,
  output data_t  aluFlags
);

  logic [8:0] sum;     // Ninth bit holds carry or borrow
  logic       carry;
  logic       setZ;    // Result drives Z

  always_comb
  begin
    sum       = '0;
    aluResult = accOut;
    carry     = flagsIn[flagC];
    setZ      = 1'b1;
    case (aluOp)
      aluAdd:
      begin
        sum       = {1'b0, accOut} + {1'b0, operand};
        aluResult = sum[7:0];
        carry     = sum[8];
      end
      aluSub:
      begin
        sum       = {1'b0, accOut} - {1'b0, operand};
        aluResult = sum[7:0];
        carry     = sum[8];  // Borrow
      end
      aluAnd:
      begin
        aluResult = accOut & operand;
        carry     = 1'b0;
      end
      aluOr:
      begin
        aluResult = accOut | operand;
        carry     = 1'b0;
      end
      aluXor:
      begin
        aluResult = accOut ^ operand;
        carry     = 1'b0;
      end
      aluCpl:
      begin
        aluResult = ~accOut;
        setZ      = 1'b0;  // Flags untouched
      end
      aluScf:
      begin
        carry = 1'b1;
        setZ  = 1'b0;
      end
      aluCcf:
      begin
        carry = ~flagsIn[flagC];
        setZ  = 1'b0;
      end
      default:
      begin
        aluResult = operand;  // Pass
        setZ      = 1'b0;
      end
    endcase

    aluFlags        = flagsIn;
    aluFlags[flagC] = carry;
    if (setZ)
      aluFlags[flagZ] = (aluResult == 8'h00);
  end

endmodule

/* busSequencer.sv */
`timescale 1ns/1ps

module busSequencer
  import microCore8Pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       wait_n,
  input  logic [2:0] mCycles,
  input  logic       isHalt,
  input  logic       writeCycle,
  output mCycle_t    mCycle,
  output tState_t    tState,
  output logic       halted,
  output logic       m1_n,
  output logic       write,
  output logic       halt_n
);

  mCycle_t mNext;
  tState_t tNext;
  logic    lastT;  // Final T-state of this M-cycle
  logic    lastM;  // Final M-cycle of this instruction

  // Opcode fetch runs to T4, all other cycles end in T3
  assign lastT = (mCycle == M1) ? (tState == T4) : (tState == T3);
  assign lastM = ({1'b0, mCycle} + 3'd1) == mCycles;

  always_comb
  begin
    mNext = mCycle;
    tNext = tState;
    if ((tState == T2) && !wait_n)
    begin
      // Hold in T2 while memory asks for wait
      tNext = T2;
    end
    else if (lastT)
    begin
      tNext = T1;
      mNext = lastM ? M1 : mCycle_t'(mCycle + 2'd1);
    end
    else
      tNext = tState_t'(tState + 2'd1);
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      mCycle <= M1;
      tState <= T1;
      halted <= 1'b0;
      m1_n   <= 1'b1;
    end
    else
    begin
      mCycle <= mNext;
      tState <= tNext;
      m1_n   <= !((mNext == M1) && ((tNext == T1) || (tNext == T2)));
      if (lastT && lastM && isHalt)
        halted <= 1'b1;  // Sticky until reset
    end
  end

  // Write strobe spans T1..T3 of the store cycle
  assign write  = writeCycle && (tState != T4);
  assign halt_n = !halted;

endmodule

/* dataPath.sv */
`timescale 1ns/1ps

module dataPath
  import microCore8Pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     wait_n,
  input  data_t    dataIn,
  input  mCycle_t  mCycle,
  input  tState_t  tState,
  input  logic     halted,
  input  addrSel_t addrSel,
  input  logic     loadTmpLo,
  input  logic     loadTmpHi,
  input  logic     jumpTaken,
  input  logic     loadAccFromBus,
  input  logic     saveAlu,
  input  logic     writeCycle,
  input  logic     incPc,
  input  data_t    aluResult,
  input  data_t    aluFlags,
  output addr_t    address,
  output data_t    dataOut,
  output data_t    ir,
  output data_t    accOut,
  output data_t    operand,
  output data_t    flags
);

  addr_t pc;
  addr_t tmpAddr;   // Jump target or memory operand address
  logic  busLatch;  // Closing clock of T2
  logic  cycleEnd;  // Edge where ACC and F commit

  assign busLatch = (tState == T2) && wait_n;
  assign cycleEnd = (mCycle == M1) ? (tState == T4) : (tState == T3);

  // ----------------------------------------
  // Read data latches
  // ----------------------------------------
  // Captured at end of T2 so the ALU sees the byte during T3
  always_ff @(posedge clk)
  begin
    if (busLatch)
    begin
      operand <= dataIn;
      if (loadTmpLo)
        tmpAddr[7:0] <= dataIn;
      if (loadTmpHi)
        tmpAddr[15:8] <= dataIn;
    end
  end

  // ----------------------------------------
  // Program counter and registers
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc      <= '0;
      ir      <= data_t'(opNop);
      accOut  <= resetAcc;
      flags   <= resetFlags;
      dataOut <= '0;
    end
    else
    begin
      if (tState == T3)
      begin
        if (jumpTaken)
          pc <= tmpAddr;
        else if (incPc && !halted)
          pc <= pc + 16'd1;
        // Halted core keeps fetching but executes nothing
        if (mCycle == M1)
          ir <= halted ? data_t'(opNop) : dataIn;
        if (!writeCycle)
          dataOut <= accOut;  // Frozen through the store cycle
      end

      if (cycleEnd)
      begin
        if (saveAlu)
        begin
          accOut <= aluResult;
          flags  <= aluFlags;
        end
        else if (loadAccFromBus)
          accOut <= dataIn;
      end
    end
  end

  assign address = (addrSel == addrTmp) ? tmpAddr : pc;

endmodule

/* microCore8.f */
microCore8Pkg.sv
alu8.sv
busSequencer.sv
opDecoder.sv
dataPath.sv
microCore8.sv
microCore8_chk.sv
microCore8Tb.sv

/* microCore8.sv */
`timescale 1ns/1ps

module microCore8
  import microCore8Pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  wait_n,
  input  data_t dataIn,
  output addr_t address,
  output data_t dataOut,
  output logic  m1_n,
  output logic  write,
  output logic  halt_n
);

  mCycle_t    mCycle;
  tState_t    tState;
  logic       halted;
  logic [2:0] mCycles;
  logic       isHalt;
  addrSel_t   addrSel;
  logic       loadTmpLo;
  logic       loadTmpHi;
  logic       jumpTaken;
  logic       loadAccFromBus;
  logic       saveAlu;
  aluOp_t     aluOp;
  logic       writeCycle;
  logic       incPc;
  data_t      ir;
  data_t      accOut;
  data_t      operand;
  data_t      flags;
  data_t      aluResult;
  data_t      aluFlags;

  // ----------------------------------------
  // Timing and control
  // ----------------------------------------
  busSequencer i_busSequencer (
    .clk        (clk),
    .reset_n    (reset_n),
    .wait_n     (wait_n),
    .mCycles    (mCycles),
    .isHalt     (isHalt),
    .writeCycle (writeCycle),
    .mCycle     (mCycle),
    .tState     (tState),
    .halted     (halted),
    .m1_n       (m1_n),
    .write      (write),
    .halt_n     (halt_n)
  );

  opDecoder i_opDecoder (
    .ir             (ir),
    .mCycle         (mCycle),
    .flags          (flags),
    .mCycles        (mCycles),
    .isHalt         (isHalt),
    .addrSel        (addrSel),
    .loadTmpLo      (loadTmpLo),
    .loadTmpHi      (loadTmpHi),
    .jumpTaken      (jumpTaken),
    .loadAccFromBus (loadAccFromBus),
    .saveAlu        (saveAlu),
    .aluOp          (aluOp),
    .writeCycle     (writeCycle),
    .incPc          (incPc)
  );

  // ----------------------------------------
  // Registers and ALU
  // ----------------------------------------
  dataPath i_dataPath (
    .clk            (clk),
    .reset_n        (reset_n),
    .wait_n         (wait_n),
    .dataIn         (dataIn),
    .mCycle         (mCycle),
    .tState         (tState),
    .halted         (halted),
    .addrSel        (addrSel),
    .loadTmpLo      (loadTmpLo),
    .loadTmpHi      (loadTmpHi),
    .jumpTaken      (jumpTaken),
    .loadAccFromBus (loadAccFromBus),
    .saveAlu        (saveAlu),
    .writeCycle     (writeCycle),
    .incPc          (incPc),
    .aluResult      (aluResult),
    .aluFlags       (aluFlags),
    .address        (address),
    .dataOut        (dataOut),
    .ir             (ir),
    .accOut         (accOut),
    .operand        (operand),
    .flags          (flags)
  );

  alu8 i_alu8 (
    .aluOp     (aluOp),
    .accOut    (accOut),
    .operand   (operand),
    .flagsIn   (flags),
    .aluResult (aluResult),
    .aluFlags  (aluFlags)
  );

endmodule

/* microCore8Patterns.txt */
// Per test: test number, program byte count (hex), program bytes from address 0,
// then expected write count and one address/data pair per write, in order
// Load and store
0001 0006
3E 5A 32 00 80 76
0001 8000 5A
// ALU ops, result stored after each
0002 0020
3E 37 C6 25 32 00 81 D6 70 32 01 81 E6 3C 32 02 81 F6 41 32 03 81
EE FF 32 04 81 2F 32 05 81 76
0006 8100 5C 8101 EC 8102 2C 8103 6D 8104 92 8105 6D
// Z and C seen through JP Z and JP C, taken path stores a marker
0003 0044
3E 42 D6 42 CA 0A 00 C3 0F 00 3E 01 32 00 82
3E F0 C6 20 DA 19 00 C3 1E 00 3E 03 32 01 82
3F DA 25 00 C3 2A 00 3E 05 32 02 82
37 DA 31 00 C3 36 00 3E 06 32 03 82
E6 00 DA 3E 00 C3 43 00 3E 07 32 04 82
76
0003 8200 01 8201 03 8203 06
// JP nn skips a store, LD A,(nn) copies a data byte
0004 0011
C3 06 00 32 00 83 3A 10 00 32 01 83 76 00 00 00 A7
0001 8301 A7
// Unsupported opcodes run as NOP, nothing executes after HALT
0005 000E
3E 11 01 06 3C 32 00 84 76 3E 22 32 01 84
0001 8400 11
// HALT alone
0006 0001 76 0000
// End of list
0000

/* microCore8Pkg.sv */
package microCore8Pkg;

  // Bus widths
  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  typedef logic [addrWidth-1:0] addr_t;
  typedef logic [dataWidth-1:0] data_t;

  // Supported opcodes, real Z80 encodings
  typedef enum logic [7:0] {
    opNop    = 8'h00,
    opLdAn   = 8'h3E,
    opAddAn  = 8'hC6,
    opSubN   = 8'hD6,
    opAndN   = 8'hE6,
    opXorN   = 8'hEE,
    opOrN    = 8'hF6,
    opCpl    = 8'h2F,
    opScf    = 8'h37,
    opCcf    = 8'h3F,
    opJp     = 8'hC3,
    opJpZ    = 8'hCA,
    opJpC    = 8'hDA,
    opLdAMem = 8'h3A,
    opLdMemA = 8'h32,
    opHalt   = 8'h76
  } opcode_t;

  typedef enum logic [3:0] {
    aluPass, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluCpl, aluScf, aluCcf
  } aluOp_t;

  typedef enum logic {addrPc, addrTmp} addrSel_t;

  // Machine cycle and T-state counters
  typedef enum logic [1:0] {M1, M2, M3, M4} mCycle_t;
  typedef enum logic [1:0] {T1, T2, T3, T4} tState_t;

  // Flag bit positions in F
  localparam int flagZ = 6;
  localparam int flagC = 0;

  localparam data_t resetAcc   = 8'hFF;
  localparam data_t resetFlags = 8'hFF;  // Z and C read as set

endpackage

/* microCore8Tb.sv */
`timescale 1ns/1ps

module microCore8Tb;
  import microCore8Pkg::*;

  logic  clk;
  logic  reset_n;
  logic  wait_n;
  data_t dataIn;
  addr_t address;
  data_t dataOut;
  logic  m1_n;
  logic  write;
  logic  halt_n;

  logic [7:0]  mem [0:65535];
  logic [15:0] patWords [0:1023];  // Raw words of the pattern file
  data_t       progBytes [$];
  addr_t       expAddr [$];
  data_t       expData [$];
  addr_t       gotAddr [$];
  data_t       gotData [$];

  integer seed        = 35529;
  logic   randomWaits = 1'b0;
  logic   running     = 1'b0;
  logic   writeHigh   = 1'b0;
  logic   m1High      = 1'b1;
  logic   haltHigh    = 1'b1;
  int     fetchCount  = 0;
  addr_t  firstFetch;
  data_t  lastOpcode;
  data_t  haltOpcode;
  int     cycleCount  = 0;
  int     cycleLimit  = 0;
  int     testNum     = 0;
  int     testErrors  = 0;
  int     passCount   = 0;
  int     failCount   = 0;

  microCore8 i_microCore8 (
    .clk     (clk),
    .reset_n (reset_n),
    .wait_n  (wait_n),
    .dataIn  (dataIn),
    .address (address),
    .dataOut (dataOut),
    .m1_n    (m1_n),
    .write   (write),
    .halt_n  (halt_n)
  );

  initial
    clk = 1'b0;

  always #2 clk = ~clk;

  // ----------------------------------------
  // Memory model and wait stimulus
  // ----------------------------------------
  always_comb
  begin
    if ($isunknown(address))
      dataIn = 8'h00;
    else
      dataIn = mem[address];
  end

  // One capture per write strobe
  always @(negedge clk)
  begin
    if (write === 1'b1 && !writeHigh)
    begin
      mem[address] = dataOut;
      gotAddr.push_back(address);
      gotData.push_back(dataOut);
    end
    writeHigh = (write === 1'b1);
  end

  // Opcode fetches marked by m1_n, opcode in hand when halt_n falls
  always @(negedge clk)
  begin
    if (halt_n === 1'b0 && haltHigh)
      haltOpcode = lastOpcode;
    if (m1_n === 1'b0 && m1High)
    begin
      if (fetchCount == 0)
        firstFetch = address;
      lastOpcode = dataIn;
      fetchCount++;
    end
    haltHigh = (halt_n !== 1'b0);
    m1High   = (m1_n !== 1'b0);
  end

  always @(posedge clk)
  begin
    #0.5;
    if (randomWaits)
      wait_n = ($random(seed) & 3) != 0;  // Low one clock in four
    else
      wait_n = 1'b1;
  end

  // Watchdog with a per-test limit from the program length
  always @(posedge clk)
  begin
    if (running)
    begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit)
      begin
        $display("Test %0d timeout: halt never reached within %0d cycles", testNum, cycleLimit);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  // ----------------------------------------
  // Test tasks
  // ----------------------------------------
  task automatic loadProgram();
    int a;
    for (a = 0; a < 65536; a++)
      mem[a] = a[15:8] ^ a[7:0] ^ 8'hA5;  // Fill uses all address bits
    for (a = 0; a < progBytes.size(); a++)
      mem[a] = progBytes[a];
  endtask

  task automatic applyReset();
    @(posedge clk);
    #0.5 reset_n = 1'b0;
    repeat (3) @(posedge clk);
    #0.5 reset_n = 1'b1;
  endtask

  task automatic compareWrites(input string name);
    int i;
    if (gotAddr.size() != expAddr.size())
    begin
      $display("Error %s write count expected %0d actual %0d",
               name, expAddr.size(), gotAddr.size());
      testErrors++;
    end
    for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++)
    begin
      if (gotAddr[i] !== expAddr[i])
      begin
        $display("Error %s write %0d address expected %h actual %h",
                 name, i, expAddr[i], gotAddr[i]);
        testErrors++;
      end
      if (gotData[i] !== expData[i])
      begin
        $display("Error %s write %0d data expected %h actual %h",
                 name, i, expData[i], gotData[i]);
        testErrors++;
      end
    end
  endtask

  task automatic runTest(input string mode);
    string name;
    logic  stayedLow;
    name       = $sformatf("test %0d %s", testNum, mode);
    testErrors = 0;
    stayedLow  = 1'b1;
    loadProgram();
    applyReset();
    gotAddr.delete();
    gotData.delete();
    fetchCount = 0;
    firstFetch = 'x;
    haltOpcode = 'x;
    cycleCount = 0;
    cycleLimit = 10 * progBytes.size() * 2;  // Doubled for wait clocks
    running    = 1'b1;
    while (halt_n !== 1'b0)
      @(negedge clk);
    running = 1'b0;
    // Halted core must stay quiet
    repeat (20)
    begin
      @(negedge clk);
      if (halt_n !== 1'b0)
        stayedLow = 1'b0;
    end
    if (!stayedLow)
    begin
      $display("%s: halt_n went high again after HALT", name);
      testErrors++;
    end
    if (firstFetch !== 16'h0000)
    begin
      $display("Error %s first fetch address expected 0000 actual %h",
               name, firstFetch);
      testErrors++;
    end
    if (haltOpcode !== 8'h76)
    begin
      $display("Error %s opcode before halt expected 76 actual %h",
               name, haltOpcode);
      testErrors++;
    end
    compareWrites(name);
    if (testErrors == 0)
    begin
      $display("%s: passed", name);
      passCount++;
    end
    else
    begin
      $display("%s: failed with %0d errors", name, testErrors);
      failCount++;
    end
  endtask

  // ----------------------------------------
  // Pattern reader and main sequence
  // ----------------------------------------
  initial
  begin
    int idx;
    int nBytes;
    int nWrites;
    int assertErrors;
    reset_n = 1'b0;
    wait_n  = 1'b1;
    $readmemh("microCore8Patterns.txt", patWords);
    idx = 0;
    while (!$isunknown(patWords[idx]) && patWords[idx] != 16'h0000)
    begin
      testNum = patWords[idx];
      nBytes  = patWords[idx + 1];
      idx     = idx + 2;
      progBytes.delete();
      repeat (nBytes)
      begin
        progBytes.push_back(patWords[idx][7:0]);
        idx++;
      end
      nWrites = patWords[idx];
      idx++;
      expAddr.delete();
      expData.delete();
      repeat (nWrites)
      begin
        expAddr.push_back(patWords[idx]);
        expData.push_back(patWords[idx + 1][7:0]);
        idx = idx + 2;
      end
      randomWaits = 1'b0;
      runTest("no waits");
      randomWaits = 1'b1;  // Same program expects the same writes
      runTest("random waits");
    end
    if (passCount + failCount == 0)
    begin
      $display("No tests were read from the pattern file");
      failCount++;
    end
    assertErrors = i_microCore8.i_microCore8Chk.errorCount;
    $display("Tests passed %0d, failed %0d, assertion failures %0d",
             passCount, failCount, assertErrors);
    if (failCount == 0 && assertErrors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* microCore8_chk.sv */
`timescale 1ns/1ps

module microCore8Chk
  import microCore8Pkg::*;
(
  input logic  clk,
  input logic  reset_n,
  input addr_t address,
  input data_t dataOut,
  input logic  m1_n,
  input logic  write,
  input logic  halt_n
);

  int errorCount = 0;  // Assertion failures so far

  // A store cycle never overlaps an opcode fetch
  noWriteInFetch: assert property (@(posedge clk) disable iff (!reset_n)
    !(write && !m1_n))
  else
  begin
    $error("write and m1_n active in the same clock");
    errorCount++;
  end

  // Bus held steady for the memory during the whole store
  writeBusStable: assert property (@(posedge clk) disable iff (!reset_n)
    (write && $past(write)) |-> ($stable(address) && $stable(dataOut)))
  else
  begin
    $error("address or dataOut changed while write was high");
    errorCount++;
  end

  // Only reset can release the halt state
  haltSticky: assert property (@(posedge clk)
    $rose(halt_n) |-> !$past(reset_n))
  else
  begin
    $error("halt_n went high again without a reset");
    errorCount++;
  end

endmodule

bind microCore8 microCore8Chk i_microCore8Chk (
  .clk     (clk),
  .reset_n (reset_n),
  .address (address),
  .dataOut (dataOut),
  .m1_n    (m1_n),
  .write   (write),
  .halt_n  (halt_n)
);

/* opDecoder.sv */
`timescale 1ns/1ps

module opDecoder
  import microCore8Pkg::*;
(
  input  data_t      ir,
  input  mCycle_t    mCycle,
  input  data_t      flags,
  output logic [2:0] mCycles,
  output logic       isHalt,
  output addrSel_t   addrSel,
  output logic       loadTmpLo,
  output logic       loadTmpHi,
  output logic       jumpTaken,
  output logic       loadAccFromBus,
  output logic       saveAlu,
  output aluOp_t     aluOp,
  output logic       writeCycle,
  output logic       incPc
);

  opcode_t op;
  logic    condMet;  // Jump condition of JP cc

  assign op = opcode_t'(ir);

  // ALU function per opcode, only used when saveAlu is set
  always_comb
  begin
    case (op)
      opAddAn: aluOp = aluAdd;
      opSubN:  aluOp = aluSub;
      opAndN:  aluOp = aluAnd;
      opOrN:   aluOp = aluOr;
      opXorN:  aluOp = aluXor;
      opCpl:   aluOp = aluCpl;
      opScf:   aluOp = aluScf;
      opCcf:   aluOp = aluCcf;
      default: aluOp = aluPass;
    endcase
  end

  always_comb
  begin
    mCycles        = 3'd1;
    isHalt         = 1'b0;
    addrSel        = addrPc;
    loadTmpLo      = 1'b0;
    loadTmpHi      = 1'b0;
    jumpTaken      = 1'b0;
    loadAccFromBus = 1'b0;
    saveAlu        = 1'b0;
    writeCycle     = 1'b0;
    incPc          = (mCycle == M1);  // Every fetch advances PC
    condMet        = 1'b1;
    case (op)
      opLdAn, opAddAn, opSubN, opAndN, opXorN, opOrN:
      begin
        mCycles        = 3'd2;
        incPc          = 1'b1;  // Skip the immediate byte
        loadAccFromBus = (mCycle == M2) && (op == opLdAn);
        saveAlu        = (mCycle == M2) && (op != opLdAn);
      end
      opCpl, opScf, opCcf:
        saveAlu = (mCycle == M1);
      opJp, opJpZ, opJpC:
      begin
        mCycles   = 3'd3;
        incPc     = 1'b1;
        loadTmpLo = (mCycle == M2);
        loadTmpHi = (mCycle == M3);
        if (op == opJpZ)
          condMet = flags[flagZ];
        else if (op == opJpC)
          condMet = flags[flagC];
        jumpTaken = (mCycle == M3) && condMet;
      end
      opLdAMem, opLdMemA:
      begin
        mCycles   = 3'd4;
        incPc     = (mCycle != M4);
        loadTmpLo = (mCycle == M2);
        loadTmpHi = (mCycle == M3);
        if (mCycle == M4)
        begin
          addrSel        = addrTmp;
          loadAccFromBus = (op == opLdAMem);
          writeCycle     = (op == opLdMemA);
        end
      end
      opHalt:
        isHalt = 1'b1;
      default:
        ;  // NOP and anything unsupported
    endcase
  end

endmodule
